//--- verilog/r42_pkg.sv
`default_nettype none

package r42_pkg;

	// ------------------------------------------------------------------------
	// datapath widths
	// ------------------------------------------------------------------------

	// input / output sample width, one part of a complex word
	localparam int DATA_W = 18;
	// headroom for the two add/sub stages and spare guard bits
	localparam int HEAD_W = 6;
	// internal word after the butterfly
	localparam int WIDE_W = DATA_W + HEAD_W;

	// sample ports at the top, lanes actually used by r4 / r2
	localparam int NUM_PORTS = 5;
	localparam int NUM_LANES = 4;

	// ------------------------------------------------------------------------
	// control fields
	// ------------------------------------------------------------------------

	localparam int FACTOR_W = 3;
	localparam int STAGE_W  = 3;
	localparam int GROWTH_W = 2;
	localparam int EXP_W    = 4;

	// factor codes, anything else is handled like radix-2
	localparam logic [FACTOR_W-1:0] FACTOR_R4 = 3'd4;
	localparam logic [FACTOR_W-1:0] FACTOR_R2 = 3'd2;

	// worst-case bit growth
	// first stage is always 2, later stages 3 for r4 and 2 for r2
	localparam logic [GROWTH_W-1:0] GROWTH_FIRST = 2'd2;
	localparam logic [GROWTH_W-1:0] GROWTH_R4    = 2'd3;

endpackage

`default_nettype wire

//--- verilog/r42_lane_if.sv
`timescale 1ns/10ps
`default_nettype none

// one complex word per butterfly lane
// used twice: wide butterfly results and scaled 18-bit results
interface r42_lane_if #(
	parameter int WIDTH = r42_pkg::DATA_W
) ();
	import r42_pkg::*;

	// real parts, lane 0..3
	logic signed [WIDTH-1:0] re [0:NUM_LANES-1];
	// imaginary parts, lane 0..3
	logic signed [WIDTH-1:0] im [0:NUM_LANES-1];

	// producer side
	modport src (
		output re,
		output im
	);

	// consumer side
	modport dst (
		input re,
		input im
	);

endinterface

`default_nettype wire

//--- verilog/r42_butterfly.sv
`timescale 1ns/10ps
`default_nettype none

module r42_butterfly #(
	parameter int DATA_W = r42_pkg::DATA_W
) (
	input  wire                                clk,
	input  wire                                rst_n,
	input  wire signed [DATA_W-1:0]            din_real_i [0:r42_pkg::NUM_PORTS-1],
	input  wire signed [DATA_W-1:0]            din_imag_i [0:r42_pkg::NUM_PORTS-1],
	input  wire        [r42_pkg::FACTOR_W-1:0] factor_i,
	input  wire                                inverse_i,
	input  wire        [r42_pkg::STAGE_W-1:0]  cnt_stage_i,
	input  wire        [r42_pkg::GROWTH_W-1:0] margin_i,
	r42_lane_if.src                            bfly_o,
	output logic       [r42_pkg::GROWTH_W-1:0] word_growth_o
);
	import r42_pkg::*;

	// one extra bit after stage 1, full headroom from the widen stage on
	localparam int S1_W   = DATA_W + 1;
	localparam int BFLY_W = DATA_W + HEAD_W;

	logic                     is_r4;
	// routed operands, index 0..3 holds t1..t4
	logic signed [DATA_W-1:0] t_re [0:NUM_LANES-1];
	logic signed [DATA_W-1:0] t_im [0:NUM_LANES-1];
	// stage 1 results x1..x4
	logic signed [S1_W-1:0]   x_re [0:NUM_LANES-1];
	logic signed [S1_W-1:0]   x_im [0:NUM_LANES-1];
	// widened copy of x1..x4
	logic signed [BFLY_W-1:0] w_re [0:NUM_LANES-1];
	logic signed [BFLY_W-1:0] w_im [0:NUM_LANES-1];
	// stage 2 before the register
	logic signed [BFLY_W-1:0] y_re [0:NUM_LANES-1];
	logic signed [BFLY_W-1:0] y_im [0:NUM_LANES-1];
	logic [GROWTH_W-1:0]      later_growth;
	logic [GROWTH_W-1:0]      worst_growth;

	assign is_r4 = (factor_i == FACTOR_R4);

	// ------------------------------------------------------------------------
	// input routing, port 4 unused
	// ------------------------------------------------------------------------
	always_comb begin
		t_re[0] = din_real_i[0];
		t_im[0] = din_imag_i[0];
		t_re[3] = din_real_i[3];
		t_im[3] = din_imag_i[3];
		if (is_r4) begin
			t_re[1] = din_real_i[1];
			t_im[1] = din_imag_i[1];
			t_re[2] = din_real_i[2];
			t_im[2] = din_imag_i[2];
		end else begin
			// r2 pairs (d0,d1) and (d2,d3)
			t_re[1] = din_real_i[2];
			t_im[1] = din_imag_i[2];
			t_re[2] = din_real_i[1];
			t_im[2] = din_imag_i[1];
		end
	end

	// ------------------------------------------------------------------------
	// stage 1 then widen, one register each
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int n = 0; n < NUM_LANES; n++) begin
				x_re[n] <= '0;
				x_im[n] <= '0;
				w_re[n] <= '0;
				w_im[n] <= '0;
			end
		end else begin
			// x1 = t1+t3, x2 = t2+t4, x3 = t1-t3, x4 = t2-t4
			x_re[0] <= S1_W'(t_re[0]) + S1_W'(t_re[2]);
			x_im[0] <= S1_W'(t_im[0]) + S1_W'(t_im[2]);
			x_re[1] <= S1_W'(t_re[1]) + S1_W'(t_re[3]);
			x_im[1] <= S1_W'(t_im[1]) + S1_W'(t_im[3]);
			x_re[2] <= S1_W'(t_re[0]) - S1_W'(t_re[2]);
			x_im[2] <= S1_W'(t_im[0]) - S1_W'(t_im[2]);
			x_re[3] <= S1_W'(t_re[1]) - S1_W'(t_re[3]);
			x_im[3] <= S1_W'(t_im[1]) - S1_W'(t_im[3]);
			// sign extend
			for (int n = 0; n < NUM_LANES; n++) begin
				w_re[n] <= BFLY_W'(x_re[n]);
				w_im[n] <= BFLY_W'(x_im[n]);
			end
		end
	end

	// ------------------------------------------------------------------------
	// stage 2
	// ------------------------------------------------------------------------
	always_comb begin
		if (is_r4) begin
			y_re[0] = w_re[0] + w_re[1];
			y_im[0] = w_im[0] + w_im[1];
			y_re[2] = w_re[0] - w_re[1];
			y_im[2] = w_im[0] - w_im[1];
			if (!inverse_i) begin
				// forward, lane 1 = x3 - j*x4
				y_re[1] = w_re[2] + w_im[3];
				y_im[1] = w_im[2] - w_re[3];
				y_re[3] = w_re[2] - w_im[3];
				y_im[3] = w_im[2] + w_re[3];
			end else begin
				// inverse, j terms flip sign
				y_re[1] = w_re[2] - w_im[3];
				y_im[1] = w_im[2] + w_re[3];
				y_re[3] = w_re[2] + w_im[3];
				y_im[3] = w_im[2] - w_re[3];
			end
		end else begin
			// two r2 butterflies already done in stage 1
			y_re[0] = w_re[0];
			y_im[0] = w_im[0];
			y_re[1] = w_re[2];
			y_im[1] = w_im[2];
			y_re[2] = w_re[1];
			y_im[2] = w_im[1];
			y_re[3] = w_re[3];
			y_im[3] = w_im[3];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int n = 0; n < NUM_LANES; n++) begin
				bfly_o.re[n] <= '0;
				bfly_o.im[n] <= '0;
			end
		end else begin
			for (int n = 0; n < NUM_LANES; n++) begin
				bfly_o.re[n] <= y_re[n];
				bfly_o.im[n] <= y_im[n];
			end
		end
	end

	// ------------------------------------------------------------------------
	// block floating point growth
	// ------------------------------------------------------------------------
	always_comb begin
		case (factor_i)
			FACTOR_R4: later_growth = GROWTH_R4;
			FACTOR_R2: later_growth = GROWTH_FIRST;
			default:   later_growth = GROWTH_FIRST;
		endcase
	end

	assign worst_growth = (cnt_stage_i == '0) ? GROWTH_FIRST : later_growth;

	// growth minus margin, never below zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			word_growth_o <= '0;
		end else if (worst_growth >= margin_i) begin
			word_growth_o <= worst_growth - margin_i;
		end else begin
			word_growth_o <= '0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/r42_scale_lane.sv
`timescale 1ns/10ps
`default_nettype none

module r42_scale_lane #(
	parameter int DATA_W = r42_pkg::DATA_W,
	parameter int WIDE_W = r42_pkg::WIDE_W
) (
	input  wire                                clk,
	input  wire                                rst_n,
	input  wire signed [WIDE_W-1:0]            in_real_i,
	input  wire signed [WIDE_W-1:0]            in_imag_i,
	input  wire        [r42_pkg::GROWTH_W-1:0] word_growth_i,
	output logic signed [DATA_W-1:0]           out_real_o,
	output logic signed [DATA_W-1:0]           out_imag_o
);

	// arithmetic shift keeps the sign, i.e. floor division by 2^g
	logic signed [WIDE_W-1:0] re_sh;
	logic signed [WIDE_W-1:0] im_sh;

	assign re_sh = in_real_i >>> word_growth_i;
	assign im_sh = in_imag_i >>> word_growth_i;

	// ------------------------------------------------------------------------
	// output register
	// ------------------------------------------------------------------------

	// low bits only, wraps on overflow
	// no saturation
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_real_o <= '0;
			out_imag_o <= '0;
		end else begin
			out_real_o <= re_sh[DATA_W-1:0];
			out_imag_o <= im_sh[DATA_W-1:0];
		end
	end

endmodule

`default_nettype wire

//--- verilog/r42_output_stage.sv
`timescale 1ns/10ps
`default_nettype none

module r42_output_stage #(
	parameter int DATA_W = r42_pkg::DATA_W
) (
	input  wire                                clk,
	input  wire                                rst_n,
	r42_lane_if.dst                            scaled_i,
	input  wire                                in_val_i,
	input  wire                                source_eop_i,
	input  wire        [r42_pkg::EXP_W-1:0]    exp_i,
	input  wire        [r42_pkg::GROWTH_W-1:0] word_growth_i,
	output logic                               out_val_o,
	output logic signed [DATA_W-1:0]           dout_real_o [0:r42_pkg::NUM_PORTS-1],
	output logic signed [DATA_W-1:0]           dout_imag_o [0:r42_pkg::NUM_PORTS-1],
	output logic       [r42_pkg::EXP_W-1:0]    exp_o
);
	import r42_pkg::*;

	// matches the four data registers in front of dout
	localparam int VAL_TAPS = 4;

	logic [VAL_TAPS-1:0] val_r;
	logic                blk_start;

	// ------------------------------------------------------------------------
	// valid delay line
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			val_r <= '0;
		end else begin
			val_r <= {val_r[VAL_TAPS-2:0], in_val_i};
		end
	end

	assign out_val_o = val_r[VAL_TAPS-1];

	// rising edge of the valid run, seen on taps 1/2
	assign blk_start = val_r[1] && !val_r[2];

	// ------------------------------------------------------------------------
	// block exponent
	// ------------------------------------------------------------------------

	// eop wins over a new block
	// sum wraps mod 16
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exp_o <= '0;
		end else if (source_eop_i) begin
			exp_o <= '0;
		end else if (blk_start) begin
			exp_o <= exp_i + EXP_W'(word_growth_i);
		end
	end

	// lane n to slot n, spare slot tied off
	for (genvar n = 0; n < NUM_PORTS; n++) begin : g_slot
		if (n < NUM_LANES) begin : g_lane
			assign dout_real_o[n] = scaled_i.re[n];
			assign dout_imag_o[n] = scaled_i.im[n];
		end else begin : g_zero
			assign dout_real_o[n] = '0;
			assign dout_imag_o[n] = '0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mrd_r42_top.sv
`timescale 1ns/10ps
`default_nettype none

module mrd_r42_top #(
	parameter int DATA_W = r42_pkg::DATA_W
) (
	input  wire                                clk,
	input  wire                                rst_n,

	// sample input, taken every cycle
	input  wire                                in_val_i,
	input  wire signed [DATA_W-1:0]            din_real_i [0:r42_pkg::NUM_PORTS-1],
	input  wire signed [DATA_W-1:0]            din_imag_i [0:r42_pkg::NUM_PORTS-1],

	// configuration, steady over a block
	input  wire        [r42_pkg::FACTOR_W-1:0] factor_i,
	input  wire        [r42_pkg::STAGE_W-1:0]  cnt_stage_i,
	input  wire                                inverse_i,
	input  wire                                source_eop_i,
	input  wire        [r42_pkg::GROWTH_W-1:0] margin_i,
	input  wire        [r42_pkg::EXP_W-1:0]    exp_i,

	// results, four cycles behind the input
	output logic                               out_val_o,
	output logic signed [DATA_W-1:0]           dout_real_o [0:r42_pkg::NUM_PORTS-1],
	output logic signed [DATA_W-1:0]           dout_imag_o [0:r42_pkg::NUM_PORTS-1],
	output logic       [r42_pkg::EXP_W-1:0]    exp_o
);
	import r42_pkg::*;

	// internal butterfly width follows DATA_W
	localparam int BFLY_W = DATA_W + HEAD_W;

	logic [GROWTH_W-1:0] word_growth;

	// wide results out of the butterfly
	r42_lane_if #(.WIDTH(BFLY_W)) bfly_bus ();
	// shifted and truncated results
	r42_lane_if #(.WIDTH(DATA_W)) scaled_bus ();

	// ------------------------------------------------------------------------
	// butterfly, three register stages
	// ------------------------------------------------------------------------
	r42_butterfly #(
		.DATA_W (DATA_W)
	) i_r42_butterfly (
		.clk           (clk),
		.rst_n         (rst_n),
		.din_real_i    (din_real_i),
		.din_imag_i    (din_imag_i),
		.factor_i      (factor_i),
		.inverse_i     (inverse_i),
		.cnt_stage_i   (cnt_stage_i),
		.margin_i      (margin_i),
		.bfly_o        (bfly_bus.src),
		.word_growth_o (word_growth)
	);

	// ------------------------------------------------------------------------
	// per-lane scaling, fourth register stage
	// ------------------------------------------------------------------------
	for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
		r42_scale_lane #(
			.DATA_W (DATA_W),
			.WIDE_W (BFLY_W)
		) i_r42_scale_lane (
			.clk           (clk),
			.rst_n         (rst_n),
			.in_real_i     (bfly_bus.re[n]),
			.in_imag_i     (bfly_bus.im[n]),
			.word_growth_i (word_growth),
			.out_real_o    (scaled_bus.re[n]),
			.out_imag_o    (scaled_bus.im[n])
		);
	end

	// ------------------------------------------------------------------------
	// valid, exponent and slot mapping
	// ------------------------------------------------------------------------
	r42_output_stage #(
		.DATA_W (DATA_W)
	) i_r42_output_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.scaled_i      (scaled_bus.dst),
		.in_val_i      (in_val_i),
		.source_eop_i  (source_eop_i),
		.exp_i         (exp_i),
		.word_growth_i (word_growth),
		.out_val_o     (out_val_o),
		.dout_real_o   (dout_real_o),
		.dout_imag_o   (dout_imag_o),
		.exp_o         (exp_o)
	);

endmodule

`default_nettype wire

//--- tests/mrd_r42_checker.sv
`timescale 1ns/10ps
`default_nettype none

// port level properties of mrd_r42_top
module mrd_r42_checker #(
	parameter int DATA_W = 18
) (
	input wire              clk,
	input wire              rst_n,
	input wire              in_val_i,
	input wire              source_eop_i,
	input wire              out_val_i,
	input wire [DATA_W-1:0] spare_real_i,
	input wire [DATA_W-1:0] spare_imag_i,
	input wire [3:0]        exp_out_i
);

	// failures seen so far, read by the testbench summary
	int assert_errs = 0;

	// ------------------------------------------------------------------------
	// valid delay and spare slot
	// ------------------------------------------------------------------------

	// four taps between in_val_i and out_val_o
	a_val_delay: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n, 4) |-> out_val_i == $past(in_val_i, 4))
	else begin
		assert_errs++;
		$error("out_val_o is not in_val_i delayed by four cycles");
	end

	// slot 4 carries no lane
	a_spare_zero: assert property (@(posedge clk) disable iff (!rst_n)
		out_val_i |-> spare_real_i == '0 && spare_imag_i == '0)
	else begin
		assert_errs++;
		$error("slot 4 is not zero while out_val_o is high");
	end

	// ------------------------------------------------------------------------
	// block exponent
	// ------------------------------------------------------------------------

	// moves only on eop or where a valid run starts on taps 1/2
	a_exp_change: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n, 4) && !$stable(exp_out_i) |->
			$past(source_eop_i) || ($past(in_val_i, 3) && !$past(in_val_i, 4)))
	else begin
		assert_errs++;
		$error("exp_o changed without eop or block start");
	end

	// eop clears at the next edge
	a_exp_clear: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) && $past(source_eop_i) |-> exp_out_i == '0)
	else begin
		assert_errs++;
		$error("exp_o not cleared after source_eop_i");
	end

endmodule

`default_nettype wire

//--- tests/tb_mrd_r42.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mrd_r42;
	import r42_pkg::*;

	localparam int NUM_ROWS   = 23;
	// block, drain and eop cycles per row, upper bound
	localparam int ROW_CYCLES = 12;
	localparam int MAX_CYCLES = 16 + NUM_ROWS * ROW_CYCLES + 50;

	// one stimulus row, growth is the hand-derived expectation
	typedef struct {
		logic [2:0]         factor;
		logic               inverse;
		logic [2:0]         stage;
		logic [1:0]         margin;
		logic [3:0]         exp_in;
		logic [1:0]         growth;
		logic [3:0]         vpat;
		logic               eop;
		logic signed [17:0] d_re [0:3];
		logic signed [17:0] d_im [0:3];
	} row_t;

	// expected output slots, one entry per driven cycle
	typedef struct packed {
		logic             valid;
		logic [4:0][17:0] re;
		logic [4:0][17:0] im;
	} entry_t;

	logic                     clk;
	logic                     rst_n;
	logic                     in_val;
	logic signed [DATA_W-1:0] din_real [0:NUM_PORTS-1];
	logic signed [DATA_W-1:0] din_imag [0:NUM_PORTS-1];
	logic [2:0]               factor;
	logic [2:0]               cnt_stage;
	logic                     inverse;
	logic                     source_eop;
	logic [1:0]               margin;
	logic [3:0]               exp_in;
	logic                     out_val;
	logic signed [DATA_W-1:0] dout_real [0:NUM_PORTS-1];
	logic signed [DATA_W-1:0] dout_imag [0:NUM_PORTS-1];
	logic [3:0]               exp_out;

	row_t   rows [0:NUM_ROWS-1];
	int     num_rows = 0;
	int     cur_row = 0;
	entry_t exp_q [$];
	entry_t mon_e;
	logic [3:0] exp_model = '0;
	int     data_errs = 0;
	int     cycle_cnt = 0;
	integer seed = 32'h0cb0fb16;

	mrd_r42_top #(
		.DATA_W (DATA_W)
	) i_mrd_r42_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_val_i     (in_val),
		.din_real_i   (din_real),
		.din_imag_i   (din_imag),
		.factor_i     (factor),
		.cnt_stage_i  (cnt_stage),
		.inverse_i    (inverse),
		.source_eop_i (source_eop),
		.margin_i     (margin),
		.exp_i        (exp_in),
		.out_val_o    (out_val),
		.dout_real_o  (dout_real),
		.dout_imag_o  (dout_imag),
		.exp_o        (exp_out)
	);

	bind mrd_r42_top mrd_r42_checker #(.DATA_W(DATA_W)) i_mrd_r42_checker (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_val_i     (in_val_i),
		.source_eop_i (source_eop_i),
		.out_val_i    (out_val_o),
		.spare_real_i (dout_real_o[4]),
		.spare_imag_i (dout_imag_o[4]),
		.exp_out_i    (exp_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// table helpers
	// ------------------------------------------------------------------------
	task automatic add_row(input logic [2:0] f, input logic inv, input logic [2:0] st,
			input logic [1:0] mg, input logic [3:0] ex, input logic [1:0] g,
			input logic [3:0] vp, input logic eop);
		rows[num_rows].factor  = f;
		rows[num_rows].inverse = inv;
		rows[num_rows].stage   = st;
		rows[num_rows].margin  = mg;
		rows[num_rows].exp_in  = ex;
		rows[num_rows].growth  = g;
		rows[num_rows].vpat    = vp;
		rows[num_rows].eop     = eop;
		for (int i = 0; i < 4; i++) begin
			rows[num_rows].d_re[i] = '0;
			rows[num_rows].d_im[i] = '0;
		end
		num_rows++;
	endtask

	// sample i of the newest row
	task automatic set_sample(input int i, input int re, input int im);
		rows[num_rows-1].d_re[i] = 18'(re);
		rows[num_rows-1].d_im[i] = 18'(im);
	endtask

	task automatic load_table();
		integer rnd;
		// impulse and constant, margin 3 so nothing is shifted
		add_row(FACTOR_R4, 0, 0, 3, 5, 0, 4'b1111, 0);
		set_sample(0, 1000, 0);
		add_row(FACTOR_R4, 0, 1, 3, 2, 0, 4'b1111, 0);
		for (int i = 0; i < 4; i++) set_sample(i, 100, -50);
		add_row(FACTOR_R4, 1, 0, 3, 6, 0, 4'b1111, 0);
		set_sample(0, 1000, 0);
		add_row(FACTOR_R4, 1, 1, 3, 7, 0, 4'b1111, 1);
		for (int i = 0; i < 4; i++) set_sample(i, 100, -50);
		add_row(FACTOR_R4, 0, 2, 3, 15, 0, 4'b1111, 0);
		for (int i = 0; i < 4; i++) set_sample(i, 2 * i + 1, 2 * i + 2);
		// radix-2 pairs, gaps in valid
		add_row(FACTOR_R2, 0, 0, 0, 3, 2, 4'b1010, 0);
		set_sample(0, 400, -400);
		set_sample(1, -100, 36);
		set_sample(2, 8, 12);
		set_sample(3, -1024, 77);
		add_row(FACTOR_R2, 1, 2, 3, 1, 0, 4'b0110, 1);
		set_sample(0, -5, 9);
		set_sample(1, 17, -3);
		set_sample(2, 131071, 0);
		set_sample(3, -131072, 1);
		// undefined code runs as radix-2
		add_row(3'd7, 0, 3, 1, 12, 1, 4'b1111, 0);
		set_sample(0, 3000, -7);
		set_sample(1, -2999, 44);
		set_sample(2, 65, 65);
		set_sample(3, -1, -1);
		// full scale, largest growth
		add_row(FACTOR_R4, 0, 1, 0, 4, 3, 4'b1111, 0);
		for (int i = 0; i < 4; i++) set_sample(i, 131071, -131072);
		add_row(FACTOR_R4, 1, 6, 0, 10, 3, 4'b1001, 0);
		for (int i = 0; i < 4; i++) set_sample(i, -131072, 131071);
		// no valid at all, exponent has to hold
		add_row(FACTOR_R2, 0, 0, 2, 9, 0, 4'b0000, 0);
		set_sample(2, 55, -55);
		// random rows, growth 0..3
		add_row(FACTOR_R4, 0, 1, 0, 1, 3, 4'b1111, 0);
		add_row(FACTOR_R4, 1, 2, 1, 2, 2, 4'b1111, 0);
		add_row(FACTOR_R4, 0, 0, 1, 3, 1, 4'b1110, 0);
		add_row(FACTOR_R4, 1, 3, 3, 4, 0, 4'b0111, 1);
		add_row(FACTOR_R2, 0, 0, 0, 5, 2, 4'b1111, 0);
		add_row(FACTOR_R2, 0, 1, 1, 6, 1, 4'b1011, 0);
		add_row(FACTOR_R2, 0, 2, 3, 7, 0, 4'b1111, 0);
		add_row(FACTOR_R4, 1, 0, 0, 8, 2, 4'b1101, 0);
		add_row(FACTOR_R4, 0, 5, 2, 14, 1, 4'b1111, 1);
		add_row(FACTOR_R4, 1, 7, 0, 15, 3, 4'b1111, 0);
		add_row(FACTOR_R2, 0, 4, 2, 11, 0, 4'b0011, 0);
		add_row(3'd5, 1, 1, 0, 13, 2, 4'b1111, 0);
		for (int r = num_rows - 12; r < num_rows; r++) begin
			for (int i = 0; i < 4; i++) begin
				rnd = $random(seed);
				rows[r].d_re[i] = rnd[17:0];
				rnd = $random(seed);
				rows[r].d_im[i] = rnd[17:0];
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// driver with reference model
	// ------------------------------------------------------------------------

	// samples rotate by c so every cycle of a block differs
	task automatic drive_cycle(input logic val, input int c, input logic eop);
		entry_t e;
		int     ar [0:3];
		int     ai [0:3];
		int     xr [0:3];
		int     xi [0:3];
		int     yr [0:3];
		int     yi [0:3];
		int     g;
		@(posedge clk);
		in_val     <= val;
		source_eop <= eop;
		factor     <= rows[cur_row].factor;
		inverse    <= rows[cur_row].inverse;
		cnt_stage  <= rows[cur_row].stage;
		margin     <= rows[cur_row].margin;
		exp_in     <= rows[cur_row].exp_in;
		for (int i = 0; i < 4; i++) begin
			ar[i] = rows[cur_row].d_re[(i + c) % 4];
			ai[i] = rows[cur_row].d_im[(i + c) % 4];
			din_real[i] <= rows[cur_row].d_re[(i + c) % 4];
			din_imag[i] <= rows[cur_row].d_im[(i + c) % 4];
		end
		// port 4 gets junk, must not show up anywhere
		din_real[4] <= 18'h15555 + 18'(c);
		din_imag[4] <= 18'h2aaaa - 18'(c);
		g = rows[cur_row].growth;
		if (rows[cur_row].factor == 3'd4) begin
			// x1..x4 in index 0..3
			xr[0] = ar[0] + ar[2];
			xi[0] = ai[0] + ai[2];
			xr[1] = ar[1] + ar[3];
			xi[1] = ai[1] + ai[3];
			xr[2] = ar[0] - ar[2];
			xi[2] = ai[0] - ai[2];
			xr[3] = ar[1] - ar[3];
			xi[3] = ai[1] - ai[3];
			yr[0] = xr[0] + xr[1];
			yi[0] = xi[0] + xi[1];
			yr[2] = xr[0] - xr[1];
			yi[2] = xi[0] - xi[1];
			// -j*(a+jb) = b - ja
			yr[1] = rows[cur_row].inverse ? xr[2] - xi[3] : xr[2] + xi[3];
			yi[1] = rows[cur_row].inverse ? xi[2] + xr[3] : xi[2] - xr[3];
			yr[3] = rows[cur_row].inverse ? xr[2] + xi[3] : xr[2] - xi[3];
			yi[3] = rows[cur_row].inverse ? xi[2] - xr[3] : xi[2] + xr[3];
		end else begin
			// d0+d1, d0-d1, d2+d3, d2-d3
			for (int p = 0; p < 2; p++) begin
				yr[2*p]   = ar[2*p] + ar[2*p+1];
				yi[2*p]   = ai[2*p] + ai[2*p+1];
				yr[2*p+1] = ar[2*p] - ar[2*p+1];
				yi[2*p+1] = ai[2*p] - ai[2*p+1];
			end
		end
		e.valid = val;
		e.re = '0;
		e.im = '0;
		// floor division by 2^g, then wrap to 18 bits
		for (int n = 0; n < 4; n++) begin
			e.re[n] = 18'(yr[n] >>> g);
			e.im[n] = 18'(yi[n] >>> g);
		end
		exp_q.push_back(e);
	endtask

	task automatic check_value(input string name, input logic [17:0] got,
			input logic [17:0] want);
		assert (got === want) else begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, want);
			data_errs++;
		end
	endtask

	// ------------------------------------------------------------------------
	// output monitor, entry driven four edges back
	// ------------------------------------------------------------------------
	always @(negedge clk) begin
		if (exp_q.size() == 5) begin
			mon_e = exp_q.pop_front();
			check_value("out_val_o", 18'(out_val), 18'(mon_e.valid));
			if (mon_e.valid) begin
				for (int n = 0; n < NUM_PORTS; n++) begin
					check_value($sformatf("dout_real_o[%0d]", n), dout_real[n], mon_e.re[n]);
					check_value($sformatf("dout_imag_o[%0d]", n), dout_imag[n], mon_e.im[n]);
				end
			end
		end
	end

	// watchdog
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > MAX_CYCLES) begin
			$display("timeout, run went past %0d cycles", MAX_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		logic v;
		rst_n      = 1'b0;
		in_val     = 1'b0;
		source_eop = 1'b0;
		factor     = '0;
		inverse    = 1'b0;
		cnt_stage  = '0;
		margin     = '0;
		exp_in     = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			din_real[i] = '0;
			din_imag[i] = '0;
		end
		load_table();
		repeat (16) drive_cycle(1'b0, 0, 1'b0);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("out_val_o", 18'(out_val), 18'd0);
		check_value("exp_o", 18'(exp_out), 18'd0);
		for (int r = 0; r < num_rows; r++) begin
			cur_row = r;
			// block of four, then drain with config held
			for (int c = 0; c < 10; c++) begin
				v = 1'b0;
				if (c < 4) v = rows[r].vpat[3 - c];
				drive_cycle(v, c, 1'b0);
			end
			if (rows[r].vpat != 4'b0000) exp_model = rows[r].exp_in + 4'(rows[r].growth);
			@(negedge clk);
			check_value("exp_o", 18'(exp_out), 18'(exp_model));
			if (rows[r].eop) begin
				drive_cycle(1'b0, 0, 1'b1);
				drive_cycle(1'b0, 0, 1'b0);
				exp_model = '0;
				@(negedge clk);
				check_value("exp_o", 18'(exp_out), 18'(exp_model));
			end
		end
		repeat (6) drive_cycle(1'b0, 0, 1'b0);
		@(negedge clk);
		$display("errors: data %0d, assertions %0d", data_errs,
			i_mrd_r42_top.i_mrd_r42_checker.assert_errs);
		if (data_errs == 0 && i_mrd_r42_top.i_mrd_r42_checker.assert_errs == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
verilog/r42_pkg.sv
verilog/r42_lane_if.sv
verilog/r42_butterfly.sv
verilog/r42_scale_lane.sv
verilog/r42_output_stage.sv
verilog/mrd_r42_top.sv
tests/mrd_r42_checker.sv
tests/tb_mrd_r42.sv

//--- Bender.yml
package:
  name: mrd_r42

sources:
  # design, compile order
  - files:
      - verilog/r42_pkg.sv
      - verilog/r42_lane_if.sv
      - verilog/r42_butterfly.sv
      - verilog/r42_scale_lane.sv
      - verilog/r42_output_stage.sv
      - verilog/mrd_r42_top.sv

  # simulation only
  - target: test
    files:
      - tests/mrd_r42_checker.sv
      - tests/tb_mrd_r42.sv
